// ==== list.f ====
source/trig_pkg.sv
source/trigger_fsm.sv
source/trigger_counters.sv
source/cmd_serializer.sv
source/tdc_measure.sv
source/word_fifo.sv
source/rr_arbiter.sv
source/trig_readout_top.sv
verif/tb_trig_readout.sv

// ==== Makefile ====
# Verilator build and run, override any variable on the command line
VERILATOR  ?= verilator
TOP        ?= tb_trig_readout
RTL_TOP    ?= trig_readout_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  ?= source/trig_pkg.sv source/trigger_fsm.sv source/trigger_counters.sv \
              source/cmd_serializer.sv source/tdc_measure.sv source/word_fifo.sv \
              source/rr_arbiter.sv source/trig_readout_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# result taken from the log
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_trig_readout.sv ====
// Trigger readout testbench
`timescale 1ns/1ps

module tb_trig_readout;

    localparam int N_RANDOM    = 40;
    localparam int N_TAIL      = 10;
    localparam int N_BACKP     = 14;
    localparam int MAX_GAP     = 48;
    localparam int CLK_NS      = 4;
    localparam int WATCHDOG_NS = ((N_RANDOM + N_TAIL + N_BACKP) * MAX_GAP + 3000) * CLK_NS;
    // trigger command, msb first on the line
    localparam logic [4:0] CMD_BITS = 5'b11101;

    logic        CLK_40;
    logic        i_rst;
    logic        i_trigger;
    logic        i_veto;
    logic        i_trigger_enable;
    logic        i_tdc_in;
    logic        i_credit_return;
    logic        o_busy;
    logic        o_cmd_data;
    logic [31:0] o_word;
    logic        o_word_valid;

    integer      seed;
    integer      cyc;
    integer      last_acc;
    integer      outstanding;
    integer      err_value;
    integer      err_other;
    integer      n_trig_words;
    integer      n_tdc_words;
    integer      i;
    logic [11:0] trig_num;
    logic [11:0] tdc_num;
    logic        tdc_armed;
    logic        credits_on;
    logic        credit_next;

    // expected words per source, in order
    logic [31:0] exp_trig [$];
    logic [31:0] exp_tdc [$];
    // cycle at which each received word gives its credit back
    integer      credit_due [$];

    trig_readout_top dut0 (
        .CLK_40           (CLK_40),
        .i_rst            (i_rst),
        .i_trigger        (i_trigger),
        .i_veto           (i_veto),
        .i_trigger_enable (i_trigger_enable),
        .i_tdc_in         (i_tdc_in),
        .i_credit_return  (i_credit_return),
        .o_busy           (o_busy),
        .o_cmd_data       (o_cmd_data),
        .o_word           (o_word),
        .o_word_valid     (o_word_valid)
    );

    initial
    begin
        CLK_40 = 1'b0;
        forever #(CLK_NS / 2) CLK_40 = ~CLK_40;
    end

    // credit pulse decided at the previous falling edge
    always @(posedge CLK_40)
    begin
        i_credit_return <= credit_next;
    end

    function automatic integer rand_range(input integer lo, input integer hi);
        integer r;
        begin
            r = $unsigned($random(seed)) % (hi - lo + 1);
            rand_range = lo + r;
        end
    endfunction

    // one rising edge, cyc names the cycle it starts
    task automatic tick();
        @(posedge CLK_40);
        cyc = cyc + 1;
    endtask

    task automatic wait_cycles(input integer n);
        repeat (n) tick();
    endtask

    // veto and enable held from two cycles before the edge to two after
    task automatic send_trigger(input logic veto, input logic enable, input logic room);
        logic accepted;
        i_veto           <= veto;
        i_trigger_enable <= enable;
        wait_cycles(2);
        accepted = enable && !veto && room;
        i_trigger <= 1'b1;
        if (accepted)
        begin
            last_acc = cyc;
            // old number, timestamp of the deciding cycle
            exp_trig.push_back({4'h1, trig_num, 16'(cyc + 2)});
            trig_num  = trig_num + 12'd1;
            tdc_armed = 1'b1;
        end
        wait_cycles(3);
        i_trigger        <= 1'b0;
        i_veto           <= 1'b0;
        i_trigger_enable <= 1'b1;
    endtask

    // only an armed TDC turns a pulse into a word
    task automatic tdc_pulse(input integer width);
        i_tdc_in <= 1'b1;
        wait_cycles(width);
        i_tdc_in <= 1'b0;
        if (tdc_armed)
        begin
            exp_tdc.push_back({4'h2, tdc_num, 16'(width)});
            tdc_num   = tdc_num + 12'd1;
            tdc_armed = 1'b0;
        end
    endtask

    task automatic random_round();
        integer kind;
        integer w;
        integer start;
        integer used;
        integer gap;
        kind = rand_range(0, 7);
        // kind 6 vetoed, kind 7 disabled
        send_trigger(kind == 6, kind != 7, 1'b1);
        used = 5;
        if (rand_range(0, 3) != 0)
        begin
            start = rand_range(1, 4);
            wait_cycles(start);
            w = rand_range(1, 20);
            tdc_pulse(w);
            used = used + start + w;
            // second pulse, TDC already disarmed
            if (rand_range(0, 3) == 0)
            begin
                wait_cycles(2);
                w = rand_range(1, 8);
                tdc_pulse(w);
                used = used + 2 + w;
            end
        end
        gap = rand_range(12, 24);
        if (gap < used + 5)
        begin
            gap = used + 5;
        end
        // gap counts from this edge to the next one
        wait_cycles(gap - used);
    endtask

    // bounded wait until every expected word and credit is back
    task automatic drain();
        integer n;
        n = 0;
        while ((exp_trig.size() != 0 || exp_tdc.size() != 0 || outstanding != 0) && n < 1000)
        begin
            tick();
            n = n + 1;
        end
        if (n >= 1000)
        begin
            $display("missing output: %0d trigger and %0d tdc words never arrived",
                     exp_trig.size(), exp_tdc.size());
            err_other = err_other + 1;
        end
    endtask

    task automatic check_outputs();
        logic        exp_busy;
        logic        exp_cmd;
        integer      k;
        logic [31:0] exp_word;
        k = cyc - last_acc;
        exp_busy = (k >= 2) && (k <= 8);
        exp_cmd  = 1'b0;
        if (k >= 3 && k <= 7)
        begin
            exp_cmd = CMD_BITS[7 - k];
        end
        if (o_busy !== exp_busy)
        begin
            $display("[ERROR] busy cycle %0d: expected %0b, actual %0b", cyc, exp_busy, o_busy);
            err_value = err_value + 1;
        end
        if (o_cmd_data !== exp_cmd)
        begin
            $display("[ERROR] cmd_data cycle %0d: expected %0b, actual %0b",
                     cyc, exp_cmd, o_cmd_data);
            err_value = err_value + 1;
        end
        if (o_word_valid === 1'b1)
        begin
            outstanding = outstanding + 1;
            if (outstanding > 4)
            begin
                $display("[ERROR] credits: expected at most 4 outstanding, actual %0d",
                         outstanding);
                err_value = err_value + 1;
            end
            credit_due.push_back(cyc + rand_range(1, 8));
            if (o_word[31:28] == 4'h1 && exp_trig.size() != 0)
            begin
                exp_word = exp_trig.pop_front();
                n_trig_words = n_trig_words + 1;
                if (o_word !== exp_word)
                begin
                    $display("[ERROR] trigger_word: expected %h, actual %h", exp_word, o_word);
                    err_value = err_value + 1;
                end
            end
            else if (o_word[31:28] == 4'h2 && exp_tdc.size() != 0)
            begin
                exp_word = exp_tdc.pop_front();
                n_tdc_words = n_tdc_words + 1;
                if (o_word !== exp_word)
                begin
                    $display("[ERROR] tdc_word: expected %h, actual %h", exp_word, o_word);
                    err_value = err_value + 1;
                end
            end
            else
            begin
                $display("unexpected output word %h at cycle %0d", o_word, cyc);
                err_other = err_other + 1;
            end
        end
        // one credit back per cycle once due
        credit_next = 1'b0;
        if (credits_on && credit_due.size() != 0)
        begin
            if (credit_due[0] <= cyc + 1)
            begin
                credit_due.pop_front();
                credit_next = 1'b1;
                outstanding = outstanding - 1;
            end
        end
    endtask

    always @(negedge CLK_40)
    begin
        if (cyc >= 0)
        begin
            check_outputs();
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        seed             = 32'h3fb;
        cyc              = -16;
        last_acc         = -1000;
        outstanding      = 0;
        err_value        = 0;
        err_other        = 0;
        n_trig_words     = 0;
        n_tdc_words      = 0;
        trig_num         = '0;
        tdc_num          = '0;
        tdc_armed        = 1'b0;
        credits_on       = 1'b1;
        credit_next      = 1'b0;
        i_rst            = 1'b1;
        i_trigger        = 1'b0;
        i_veto           = 1'b0;
        i_trigger_enable = 1'b1;
        i_tdc_in         = 1'b0;
        i_credit_return  = 1'b0;
        wait_cycles(16);
        // cycle 0 is the first one out of reset
        i_rst <= 1'b0;
        wait_cycles(4);
        repeat (N_RANDOM) random_round();
        drain();
        // no credits, queue fills behind the first four words
        credits_on = 1'b0;
        for (i = 0; i < N_BACKP; i = i + 1)
        begin
            send_trigger(1'b0, 1'b1, i < 12);
            wait_cycles(9);
        end
        credits_on = 1'b1;
        drain();
        repeat (N_TAIL) random_round();
        drain();
        wait_cycles(10);
        $display("errors %0d (wrong value %0d, other %0d), trigger words %0d, tdc words %0d",
                 err_value + err_other, err_value, err_other, n_trig_words, n_tdc_words);
        if (err_value + err_other == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== source/trig_readout_top.sv ====
// Trigger and readout top level
`timescale 1ns/1ps

module trig_readout_top #(
    parameter int TRIG_FIFO_DEPTH = 8,
    parameter int TDC_FIFO_DEPTH  = 8,
    parameter int CREDITS         = 4
) (
    input  logic                 CLK_40,
    input  logic                 i_rst,
    input  logic                 i_trigger,
    input  logic                 i_veto,
    input  logic                 i_trigger_enable,
    input  logic                 i_tdc_in,
    input  logic                 i_credit_return,
    output logic                 o_busy,
    output logic                 o_cmd_data,
    output trig_pkg::data_word_t o_word,
    output logic                 o_word_valid
);

    // trigger handshake
    logic accept;
    logic cmd_ready;

    // counters
    trig_pkg::timestamp_t timestamp;
    trig_pkg::trig_num_t  trig_num;

    // queues
    trig_pkg::data_word_t   trig_word;
    trig_pkg::data_word_t   tdc_word;
    trig_pkg::word_stream_t head_trig;
    trig_pkg::word_stream_t head_tdc;
    logic                   trig_full;
    logic                   tdc_full;
    logic                   tdc_push;
    logic                   pop_trig;
    logic                   pop_tdc;

    // number before increment, timestamp of the accepting cycle
    assign trig_word = {trig_pkg::HDR_TRIGGER, trig_num, timestamp};

    trigger_fsm trigger_fsm0 (
        .CLK_40           (CLK_40),
        .i_rst            (i_rst),
        .i_trigger        (i_trigger),
        .i_veto           (i_veto),
        .i_trigger_enable (i_trigger_enable),
        .i_queue_full     (trig_full),
        .i_cmd_ready      (cmd_ready),
        .o_accept         (accept),
        .o_busy           (o_busy)
    );

    trigger_counters trigger_counters0 (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_accept    (accept),
        .o_timestamp (timestamp),
        .o_trig_num  (trig_num)
    );

    cmd_serializer cmd_serializer0 (
        .CLK_40     (CLK_40),
        .i_rst      (i_rst),
        .i_start    (accept),
        .o_cmd_data (o_cmd_data),
        .o_ready    (cmd_ready)
    );

    // accept also arms the tdc
    tdc_measure tdc_measure0 (
        .CLK_40       (CLK_40),
        .i_rst        (i_rst),
        .i_arm        (accept),
        .i_tdc_in     (i_tdc_in),
        .i_queue_full (tdc_full),
        .o_push       (tdc_push),
        .o_word       (tdc_word)
    );

    word_fifo #(
        .DEPTH (TRIG_FIFO_DEPTH)
    ) trig_fifo0 (
        .CLK_40 (CLK_40),
        .i_rst  (i_rst),
        .i_push (accept),
        .i_word (trig_word),
        .i_pop  (pop_trig),
        .o_head (head_trig),
        .o_full (trig_full)
    );

    word_fifo #(
        .DEPTH (TDC_FIFO_DEPTH)
    ) tdc_fifo0 (
        .CLK_40 (CLK_40),
        .i_rst  (i_rst),
        .i_push (tdc_push),
        .i_word (tdc_word),
        .i_pop  (pop_tdc),
        .o_head (head_tdc),
        .o_full (tdc_full)
    );

    rr_arbiter #(
        .CREDITS (CREDITS)
    ) rr_arbiter0 (
        .CLK_40          (CLK_40),
        .i_rst           (i_rst),
        .i_head_trig     (head_trig),
        .i_head_tdc      (head_tdc),
        .i_credit_return (i_credit_return),
        .o_pop_trig      (pop_trig),
        .o_pop_tdc       (pop_tdc),
        .o_word          (o_word),
        .o_word_valid    (o_word_valid)
    );

endmodule

// ==== source/rr_arbiter.sv ====
// Round robin output arbiter with credits
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int CREDITS = 4
) (
    input  logic                   CLK_40,
    input  logic                   i_rst,
    input  trig_pkg::word_stream_t i_head_trig,
    input  trig_pkg::word_stream_t i_head_tdc,
    input  logic                   i_credit_return,
    output logic                   o_pop_trig,
    output logic                   o_pop_tdc,
    output trig_pkg::data_word_t   o_word,
    output logic                   o_word_valid
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credits;
    logic          can_send;
    logic          send;
    // last word came from the tdc queue
    logic          last_tdc;

    assign can_send = (credits != '0);

    // the loser of the last grant goes first on a tie
    assign o_pop_trig = can_send & i_head_trig.valid & (~i_head_tdc.valid | last_tdc);
    assign o_pop_tdc  = can_send & i_head_tdc.valid & ~o_pop_trig;
    assign send       = o_pop_trig | o_pop_tdc;

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            credits      <= CW'(CREDITS);
            last_tdc     <= 1'b0;
            o_word_valid <= 1'b0;
        end
        else
        begin
            // one credit per word, one back per return pulse
            credits      <= credits - CW'(send) + CW'(i_credit_return);
            o_word_valid <= send;
            if (send)
            begin
                last_tdc <= o_pop_tdc;
            end
        end
    end

    // output word register
    always_ff @(posedge CLK_40)
    begin
        if (o_pop_trig)
        begin
            o_word <= i_head_trig.word;
        end
        else if (o_pop_tdc)
        begin
            o_word <= i_head_tdc.word;
        end
    end

endmodule

// ==== source/word_fifo.sv ====
// Synchronous word FIFO
`timescale 1ns/1ps

module word_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                   CLK_40,
    input  logic                   i_rst,
    input  logic                   i_push,
    input  trig_pkg::data_word_t   i_word,
    input  logic                   i_pop,
    output trig_pkg::word_stream_t o_head,
    output logic                   o_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    trig_pkg::data_word_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & o_head.valid;

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap at DEPTH, any depth allowed
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    // storage
    always_ff @(posedge CLK_40)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= i_word;
        end
    end

    // head valid whenever not empty
    assign o_head.valid = (count != '0);
    assign o_head.word  = mem[rd_ptr];
    assign o_full       = (count == CW'(DEPTH));

endmodule

// ==== source/tdc_measure.sv ====
// Armed pulse width measurement
`timescale 1ns/1ps

module tdc_measure (
    input  logic                 CLK_40,
    input  logic                 i_rst,
    input  logic                 i_arm,
    input  logic                 i_tdc_in,
    input  logic                 i_queue_full,
    output logic                 o_push,
    output trig_pkg::data_word_t o_word
);

    logic                 tdc_q;
    logic                 tdc_q2;
    logic                 armed;
    logic                 measuring;
    logic                 done;
    trig_pkg::tdc_width_t width;
    trig_pkg::trig_num_t  event_num;

    // pulse ends while measuring
    assign done = measuring & ~tdc_q;

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            tdc_q     <= 1'b0;
            tdc_q2    <= 1'b0;
            armed     <= 1'b0;
            measuring <= 1'b0;
            o_push    <= 1'b0;
            event_num <= '0;
        end
        else
        begin
            tdc_q  <= i_tdc_in;
            tdc_q2 <= tdc_q;
            o_push <= 1'b0;
            // repeated arm keeps a single pending measurement
            armed  <= (armed & ~done) | i_arm;
            if (armed && !measuring && tdc_q && !tdc_q2)
            begin
                measuring <= 1'b1;
            end
            else if (done)
            begin
                measuring <= 1'b0;
                // full queue drops the word
                if (!i_queue_full)
                begin
                    o_push    <= 1'b1;
                    event_num <= event_num + 1'b1;
                end
            end
        end
    end

    // width count and word, payload only
    always_ff @(posedge CLK_40)
    begin
        if (armed && !measuring && tdc_q && !tdc_q2)
        begin
            width <= trig_pkg::tdc_width_t'(1);
        end
        else if (measuring && tdc_q && (width != '1))
        begin
            width <= width + 1'b1;
        end
        if (done)
        begin
            o_word <= {trig_pkg::HDR_TDC, event_num, width};
        end
    end

endmodule

// ==== source/cmd_serializer.sv ====
// Trigger command serializer
`timescale 1ns/1ps

module cmd_serializer (
    input  logic CLK_40,
    input  logic i_rst,
    input  logic i_start,
    output logic o_cmd_data,
    output logic o_ready
);

    localparam int CNT_W = $clog2(trig_pkg::CMD_LEN);

    logic [trig_pkg::CMD_LEN-1:0] shreg;
    logic [CNT_W-1:0]             bit_cnt;
    logic                         shifting;

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            shifting <= 1'b0;
            shreg    <= '0;
            bit_cnt  <= '0;
        end
        else if (i_start && !shifting)
        begin
            // load the pattern, first bit goes out next cycle
            shifting <= 1'b1;
            shreg    <= trig_pkg::CMD_TRIGGER;
            bit_cnt  <= '0;
        end
        else if (shifting)
        begin
            shreg <= {shreg[trig_pkg::CMD_LEN-2:0], 1'b0};
            // last bit on the line this cycle
            if (bit_cnt == CNT_W'(trig_pkg::CMD_LEN - 1))
            begin
                shifting <= 1'b0;
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // msb first, line idles low
    assign o_cmd_data = shifting & shreg[trig_pkg::CMD_LEN-1];

    // rises the cycle after the last bit
    assign o_ready = ~shifting;

endmodule

// ==== source/trigger_counters.sv ====
// Timestamp and trigger counters
`timescale 1ns/1ps

module trigger_counters (
    input  logic                  CLK_40,
    input  logic                  i_rst,
    input  logic                  i_accept,
    output trig_pkg::timestamp_t  o_timestamp,
    output trig_pkg::trig_num_t   o_trig_num
);

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            // zero in the first cycle after reset release
            o_timestamp <= '0;
            o_trig_num  <= '0;
        end
        else
        begin
            // free running, wraps
            o_timestamp <= o_timestamp + 1'b1;
            // advances after the word took the old value
            if (i_accept)
            begin
                o_trig_num <= o_trig_num + 1'b1;
            end
        end
    end

endmodule

// ==== source/trigger_fsm.sv ====
// Trigger acceptance FSM
`timescale 1ns/1ps

module trigger_fsm (
    input  logic CLK_40,
    input  logic i_rst,
    input  logic i_trigger,
    input  logic i_veto,
    input  logic i_trigger_enable,
    input  logic i_queue_full,
    input  logic i_cmd_ready,
    output logic o_accept,
    output logic o_busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY_LOW,
        ST_WAIT_READY_HIGH
    } trig_state_t;

    trig_state_t state;

    // input registers, one stage each
    logic trig_q;
    logic trig_q2;
    logic veto_q;
    logic ready_q;

    logic trig_edge;
    logic ready_rise;

    // rising edge of the registered trigger
    assign trig_edge = trig_q & ~trig_q2;
    // acknowledge from the command serializer
    assign ready_rise = i_cmd_ready & ~ready_q;

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            trig_q   <= 1'b0;
            trig_q2  <= 1'b0;
            veto_q   <= 1'b0;
            // ready idles high, avoid a false rise after reset
            ready_q  <= 1'b1;
            state    <= ST_IDLE;
            o_accept <= 1'b0;
        end
        else
        begin
            trig_q   <= i_trigger;
            trig_q2  <= trig_q;
            veto_q   <= i_veto;
            ready_q  <= i_cmd_ready;
            o_accept <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    // rejected edges leave everything untouched
                    if (trig_edge && i_trigger_enable && !veto_q && !i_queue_full)
                    begin
                        o_accept <= 1'b1;
                        state    <= ST_WAIT_READY_LOW;
                    end
                end
                ST_WAIT_READY_LOW:
                begin
                    // serializer has taken the start
                    if (!i_cmd_ready)
                    begin
                        state <= ST_WAIT_READY_HIGH;
                    end
                end
                ST_WAIT_READY_HIGH:
                begin
                    // command fully shifted out
                    if (ready_rise)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // busy for the whole handling, edges meanwhile are ignored
    assign o_busy = (state != ST_IDLE);

endmodule

// ==== source/trig_pkg.sv ====
// Trigger readout shared definitions
package trig_pkg;

    // output data word, header in the top nibble
    typedef logic [31:0] data_word_t;
    typedef logic [3:0]  header_t;

    // cycle timestamp since reset release
    typedef logic [15:0] timestamp_t;

    // trigger or event number, wraps around
    typedef logic [11:0] trig_num_t;

    // measured pulse width in cycles, saturates
    typedef logic [15:0] tdc_width_t;

    // queue head as seen by the arbiter
    typedef struct packed {
        logic       valid;
        data_word_t word;
    } word_stream_t;

    // source header codes
    localparam header_t HDR_TRIGGER = 4'd1;
    localparam header_t HDR_TDC     = 4'd2;

    // trigger command sent to the front end, msb first
    localparam int CMD_LEN = 5;
    localparam logic [CMD_LEN-1:0] CMD_TRIGGER = 5'b11101;

endpackage
